// ==== verilog/gate_ctrl_pkg.sv ====
package gate_ctrl_pkg;

  // Event duration counters.
  localparam int count_width = 40;

  // Phase words for the transmit and receive NCOs.
  localparam int phase_width = 30;

  // Transmit output level.
  localparam int level_width = 16;

  // Transmit event, 128 bits.
  // Bit map from the LSB: duration 39:0, sync 40, gate 41, level 59:44,
  // tx phase 93:64, rx phase 123:94.
  typedef struct packed {
    logic [3:0]             spare_hi;
    logic [phase_width-1:0] rx_phase;
    logic [phase_width-1:0] tx_phase;
    logic [3:0]             spare_mid;
    logic [level_width-1:0] level;
    logic [1:0]             spare_lo;
    logic                   gate;
    logic                   sync;
    logic [count_width-1:0] duration;
  } tx_event_t;

  // Receive event, 64 bits.
  // Duration counts valid samples, keep selects forwarding.
  typedef struct packed {
    logic [22:0]            spare;
    logic                   keep;
    logic [count_width-1:0] duration;
  } rx_event_t;

endpackage

// ==== verilog/event_fifo.sv ====
`timescale 1ns/1ps

module event_fifo #(
  parameter int FIFO_DEPTH = 4,
  parameter type payload_t = logic [63:0]
) (
  input  logic     aclk,
  input  logic     aresetn,

  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,

  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int addr_width = $clog2(FIFO_DEPTH);

  payload_t mem [FIFO_DEPTH];

  // One extra bit tells full from empty.
  logic [addr_width:0] wr_ptr;
  logic [addr_width:0] rd_ptr;

  logic run_reg;
  logic empty;
  logic full;
  logic wr_en;
  logic rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                 (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

  // A full FIFO still takes a word when one leaves.
  assign in_ready = run_reg & (~full | out_ready);
  assign wr_en    = in_valid & in_ready;

  assign out_valid = ~empty;
  assign rd_en     = out_valid & out_ready;

  // Head of queue, no read latency.
  assign out_data = mem[rd_ptr[addr_width-1:0]];

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      run_reg <= 1'b0;
    end
    else
    begin
      run_reg <= 1'b1;
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr[addr_width-1:0]] <= in_data;
    end
  end

endmodule

// ==== verilog/tx_event_timer.sv ====
`timescale 1ns/1ps

module tx_event_timer (
  input  logic                                    aclk,
  input  logic                                    aresetn,

  input  gate_ctrl_pkg::tx_event_t                evt_data,
  input  logic                                    evt_valid,
  output logic                                    evt_ready,

  output logic                                    sync,
  output logic                                    gate,
  output logic [gate_ctrl_pkg::level_width-1:0]   level,
  output logic [gate_ctrl_pkg::phase_width-1:0]   tx_phase,
  output logic [gate_ctrl_pkg::phase_width-1:0]   rx_phase
);

  logic [gate_ctrl_pkg::count_width-1:0] cnt_reg;

  // Fields of the event in progress.
  logic                                  sync_flag_reg;
  logic                                  gate_flag_reg;
  logic [gate_ctrl_pkg::level_width-1:0] level_reg;
  logic [gate_ctrl_pkg::phase_width-1:0] tx_phase_reg;
  logic [gate_ctrl_pkg::phase_width-1:0] rx_phase_reg;

  logic sync_reg;
  logic gate_reg;

  logic busy;
  logic accept;
  logic active;
  logic sync_next;
  logic gate_next;

  assign busy      = |cnt_reg;
  assign evt_ready = ~busy;
  assign accept    = evt_valid & ~busy;
  assign active    = busy | accept;

  // New event's flags go out on the accept cycle.
  assign sync_next = busy ? sync_flag_reg : evt_data.sync;
  assign gate_next = busy ? gate_flag_reg : evt_data.gate;

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      cnt_reg       <= '0;
      sync_flag_reg <= 1'b0;
      gate_flag_reg <= 1'b0;
      level_reg     <= '0;
      tx_phase_reg  <= '0;
      rx_phase_reg  <= '0;
      sync_reg      <= 1'b0;
      gate_reg      <= 1'b0;
    end
    else
    begin
      if (busy)
      begin
        cnt_reg <= cnt_reg - 1'b1;
      end
      else if (accept)
      begin
        cnt_reg       <= evt_data.duration;
        sync_flag_reg <= evt_data.sync;
        gate_flag_reg <= evt_data.gate;
        level_reg     <= evt_data.level;
        tx_phase_reg  <= evt_data.tx_phase;
        rx_phase_reg  <= evt_data.rx_phase;
      end
      sync_reg <= sync_next & active;
      gate_reg <= gate_next & active;
    end
  end

  assign sync     = sync_reg;
  assign gate     = gate_reg;
  assign level    = level_reg;
  assign tx_phase = tx_phase_reg;
  assign rx_phase = rx_phase_reg;

endmodule

// ==== verilog/rx_sample_gate.sv ====
`timescale 1ns/1ps

module rx_sample_gate #(
  parameter int SAMPLE_WIDTH = 128
) (
  input  logic                     aclk,
  input  logic                     aresetn,

  input  gate_ctrl_pkg::rx_event_t evt_data,
  input  logic                     evt_valid,
  output logic                     evt_ready,

  input  logic [SAMPLE_WIDTH-1:0]  s_data,
  input  logic                     s_valid,

  output logic [SAMPLE_WIDTH-1:0]  m_data,
  output logic                     m_valid
);

  // Remaining samples of the current window.
  logic [gate_ctrl_pkg::count_width-1:0] cnt_reg;
  logic                                  keep_reg;

  logic [SAMPLE_WIDTH-1:0] data_reg;
  logic                    valid_reg;

  logic busy;
  logic accept;
  logic keep_now;

  assign busy = |cnt_reg;

  // Events start only on a valid sample.
  assign evt_ready = ~busy & s_valid;
  assign accept    = evt_valid & evt_ready;

  assign keep_now = busy ? keep_reg : evt_data.keep;

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      cnt_reg   <= '0;
      keep_reg  <= 1'b0;
      valid_reg <= 1'b0;
    end
    else
    begin
      if (s_valid)
      begin
        if (busy)
        begin
          cnt_reg <= cnt_reg - 1'b1;
        end
        else if (accept)
        begin
          cnt_reg  <= evt_data.duration;
          keep_reg <= evt_data.keep;
        end
      end
      valid_reg <= s_valid & keep_now & (busy | accept);
    end
  end

  // Sample register.
  always_ff @(posedge aclk)
  begin
    data_reg <= s_data;
  end

  assign m_data  = data_reg;
  assign m_valid = valid_reg;

endmodule

// ==== verilog/gate_controller_top.sv ====
`timescale 1ns/1ps

module gate_controller_top #(
  parameter int FIFO_DEPTH   = 4,
  parameter int SAMPLE_WIDTH = 128
) (
  input  logic                                  aclk,
  input  logic                                  aresetn,

  input  gate_ctrl_pkg::tx_event_t              tx_evt_data,
  input  logic                                  tx_evt_valid,
  output logic                                  tx_evt_ready,

  input  gate_ctrl_pkg::rx_event_t              rx_evt_data,
  input  logic                                  rx_evt_valid,
  output logic                                  rx_evt_ready,

  input  logic [SAMPLE_WIDTH-1:0]               s_data,
  input  logic                                  s_valid,

  output logic [SAMPLE_WIDTH-1:0]               m_data,
  output logic                                  m_valid,

  output logic                                  sync,
  output logic                                  gate,
  output logic [gate_ctrl_pkg::level_width-1:0] level,
  output logic [gate_ctrl_pkg::phase_width-1:0] tx_phase,
  output logic [gate_ctrl_pkg::phase_width-1:0] rx_phase
);

  gate_ctrl_pkg::tx_event_t tx_head_data;
  logic                     tx_head_valid;
  logic                     tx_head_ready;

  gate_ctrl_pkg::rx_event_t rx_head_data;
  logic                     rx_head_valid;
  logic                     rx_head_ready;

  event_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .payload_t  (gate_ctrl_pkg::tx_event_t)
  ) tx_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_data   (tx_evt_data),
    .in_valid  (tx_evt_valid),
    .in_ready  (tx_evt_ready),
    .out_data  (tx_head_data),
    .out_valid (tx_head_valid),
    .out_ready (tx_head_ready)
  );

  event_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .payload_t  (gate_ctrl_pkg::rx_event_t)
  ) rx_fifo (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_data   (rx_evt_data),
    .in_valid  (rx_evt_valid),
    .in_ready  (rx_evt_ready),
    .out_data  (rx_head_data),
    .out_valid (rx_head_valid),
    .out_ready (rx_head_ready)
  );

  tx_event_timer tx_timer (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .evt_data  (tx_head_data),
    .evt_valid (tx_head_valid),
    .evt_ready (tx_head_ready),
    .sync      (sync),
    .gate      (gate),
    .level     (level),
    .tx_phase  (tx_phase),
    .rx_phase  (rx_phase)
  );

  rx_sample_gate #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) rx_gate (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .evt_data  (rx_head_data),
    .evt_valid (rx_head_valid),
    .evt_ready (rx_head_ready),
    .s_data    (s_data),
    .s_valid   (s_valid),
    .m_data    (m_data),
    .m_valid   (m_valid)
  );

endmodule

// ==== verification/gate_controller_tb.sv ====
`timescale 1ns/1ps

module gate_controller_tb;

  localparam int fifo_depth   = 4;
  localparam int sample_width = 128;
  localparam int num_events   = 120;

  // Twice a worst-case bound of 16 cycles per event plus reset and drain.
  localparam int max_cycles = 2 * (num_events * 16 + 80);

  logic aclk = 1'b0;
  logic aresetn;

  gate_ctrl_pkg::tx_event_t tx_evt_data;
  logic                     tx_evt_valid;
  logic                     tx_evt_ready;
  gate_ctrl_pkg::rx_event_t rx_evt_data;
  logic                     rx_evt_valid;
  logic                     rx_evt_ready;

  logic [sample_width-1:0] s_data;
  logic                    s_valid;
  logic [sample_width-1:0] m_data;
  logic                    m_valid;

  logic                                  sync;
  logic                                  gate;
  logic [gate_ctrl_pkg::level_width-1:0] level;
  logic [gate_ctrl_pkg::phase_width-1:0] tx_phase;
  logic [gate_ctrl_pkg::phase_width-1:0] rx_phase;

  integer seed;
  int     errors = 0;
  int     cycles = 0;
  logic   samples_on = 1'b0;

  // Reference model state.
  gate_ctrl_pkg::tx_event_t              tx_q[$];
  gate_ctrl_pkg::rx_event_t              rx_q[$];
  gate_ctrl_pkg::tx_event_t              cur_tx;
  logic [gate_ctrl_pkg::count_width-1:0] t_rem;
  logic [gate_ctrl_pkg::count_width-1:0] r_rem;
  logic                                  r_keep;
  logic                                  run = 1'b0;
  logic                                  check_en = 1'b0;
  int                                    tx_fill = 0;
  int                                    rx_fill = 0;

  logic                                  exp_sync;
  logic                                  exp_gate;
  logic [gate_ctrl_pkg::level_width-1:0] exp_level;
  logic [gate_ctrl_pkg::phase_width-1:0] exp_tx_phase;
  logic [gate_ctrl_pkg::phase_width-1:0] exp_rx_phase;
  logic                                  exp_m_valid;
  logic [sample_width-1:0]               exp_m_data;

  int tx_started = 0;
  int rx_started = 0;
  int kept_exp = 0;
  int kept_seen = 0;
  int tx_full_cycles = 0;
  int rx_full_cycles = 0;

  gate_controller_top #(
    .FIFO_DEPTH   (fifo_depth),
    .SAMPLE_WIDTH (sample_width)
  ) uut (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .tx_evt_data  (tx_evt_data),
    .tx_evt_valid (tx_evt_valid),
    .tx_evt_ready (tx_evt_ready),
    .rx_evt_data  (rx_evt_data),
    .rx_evt_valid (rx_evt_valid),
    .rx_evt_ready (rx_evt_ready),
    .s_data       (s_data),
    .s_valid      (s_valid),
    .m_data       (m_data),
    .m_valid      (m_valid),
    .sync         (sync),
    .gate         (gate),
    .level        (level),
    .tx_phase     (tx_phase),
    .rx_phase     (rx_phase)
  );

  always #4 aclk = ~aclk;

  // Model steps with the DUT on every edge.
  always @(posedge aclk)
  begin : track_model
    gate_ctrl_pkg::tx_event_t tx_ev;
    gate_ctrl_pkg::rx_event_t rx_ev;
    check_en <= 1'b1;
    if (!aresetn)
    begin
      tx_q.delete();
      rx_q.delete();
      run          <= 1'b0;
      t_rem        <= '0;
      r_rem        <= '0;
      exp_sync     <= 1'b0;
      exp_gate     <= 1'b0;
      exp_level    <= '0;
      exp_tx_phase <= '0;
      exp_rx_phase <= '0;
      exp_m_valid  <= 1'b0;
      tx_fill      <= 0;
      rx_fill      <= 0;
    end
    else
    begin
      run <= 1'b1;
      if (tx_fill == fifo_depth)
        tx_full_cycles++;
      if (rx_fill == fifo_depth)
        rx_full_cycles++;
      if (m_valid)
        kept_seen++;

      // Transmit timer with N+1 active cycles per event.
      if (t_rem != 0)
      begin
        t_rem    <= t_rem - 1'b1;
        exp_sync <= cur_tx.sync;
        exp_gate <= cur_tx.gate;
      end
      else if (tx_q.size() != 0)
      begin
        tx_ev = tx_q.pop_front();
        tx_started++;
        cur_tx       <= tx_ev;
        t_rem        <= tx_ev.duration;
        exp_sync     <= tx_ev.sync;
        exp_gate     <= tx_ev.gate;
        exp_level    <= tx_ev.level;
        exp_tx_phase <= tx_ev.tx_phase;
        exp_rx_phase <= tx_ev.rx_phase;
      end
      else
      begin
        exp_sync <= 1'b0;
        exp_gate <= 1'b0;
      end
      if (tx_evt_valid && tx_evt_ready)
        tx_q.push_back(tx_evt_data);
      tx_fill <= tx_q.size();

      // Receive gate counts valid samples only.
      exp_m_data  <= s_data;
      exp_m_valid <= 1'b0;
      if (s_valid && r_rem != 0)
      begin
        r_rem       <= r_rem - 1'b1;
        exp_m_valid <= r_keep;
        if (r_keep)
          kept_exp++;
      end
      else if (s_valid && rx_q.size() != 0)
      begin
        rx_ev = rx_q.pop_front();
        rx_started++;
        r_rem       <= rx_ev.duration;
        r_keep      <= rx_ev.keep;
        exp_m_valid <= rx_ev.keep;
        if (rx_ev.keep)
          kept_exp++;
      end
      if (rx_evt_valid && rx_evt_ready)
        rx_q.push_back(rx_evt_data);
      rx_fill <= rx_q.size();
    end
  end

  sync_check: assert property (@(posedge aclk) check_en |-> sync == exp_sync)
  else
  begin
    errors++;
    $display("ERR sync got %h expected %h", $sampled(sync), $sampled(exp_sync));
  end

  gate_check: assert property (@(posedge aclk) check_en |-> gate == exp_gate)
  else
  begin
    errors++;
    $display("ERR gate got %h expected %h", $sampled(gate), $sampled(exp_gate));
  end

  level_check: assert property (@(posedge aclk) check_en |-> level == exp_level)
  else
  begin
    errors++;
    $display("ERR level got %h expected %h", $sampled(level), $sampled(exp_level));
  end

  tx_phase_check: assert property (@(posedge aclk) check_en |-> tx_phase == exp_tx_phase)
  else
  begin
    errors++;
    $display("ERR tx_phase got %h expected %h", $sampled(tx_phase), $sampled(exp_tx_phase));
  end

  rx_phase_check: assert property (@(posedge aclk) check_en |-> rx_phase == exp_rx_phase)
  else
  begin
    errors++;
    $display("ERR rx_phase got %h expected %h", $sampled(rx_phase), $sampled(exp_rx_phase));
  end

  m_valid_check: assert property (@(posedge aclk) check_en |-> m_valid == exp_m_valid)
  else
  begin
    errors++;
    $display("ERR m_valid got %h expected %h", $sampled(m_valid), $sampled(exp_m_valid));
  end

  m_data_check: assert property (@(posedge aclk) check_en && exp_m_valid |-> m_data == exp_m_data)
  else
  begin
    errors++;
    $display("ERR m_data got %h expected %h", $sampled(m_data), $sampled(exp_m_data));
  end

  // Full FIFO accepts only while its head leaves.
  tx_ready_check: assert property (@(posedge aclk) check_en |->
    tx_evt_ready == (run && (tx_fill < fifo_depth || t_rem == 0)))
  else
  begin
    errors++;
    $display("ERR tx_evt_ready got %h with fill %h", $sampled(tx_evt_ready), $sampled(tx_fill));
  end

  rx_ready_check: assert property (@(posedge aclk) check_en |->
    rx_evt_ready == (run && (rx_fill < fifo_depth || (r_rem == 0 && s_valid))))
  else
  begin
    errors++;
    $display("ERR rx_evt_ready got %h with fill %h", $sampled(rx_evt_ready), $sampled(rx_fill));
  end

  // Sample stream with random holes.
  always @(posedge aclk)
  begin
    #1;
    s_valid = samples_on && (($random(seed) & 3) != 0);
    s_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
  end

  always @(posedge aclk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("Run stopped after %0d cycles with events still pending.", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic gate_ctrl_pkg::tx_event_t rand_tx_event();
    gate_ctrl_pkg::tx_event_t ev;
    ev          = '0;
    ev.duration = {$random(seed)} % 8;
    ev.sync     = $random(seed) & 1;
    ev.gate     = $random(seed) & 1;
    ev.level    = 16'($random(seed));
    ev.tx_phase = 30'($random(seed));
    ev.rx_phase = 30'($random(seed));
    return ev;
  endfunction

  function automatic gate_ctrl_pkg::rx_event_t rand_rx_event();
    gate_ctrl_pkg::rx_event_t ev;
    ev          = '0;
    ev.duration = {$random(seed)} % 8;
    ev.keep     = $random(seed) & 1;
    return ev;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge aclk);
    #1;
  endtask

  // Ready is stable at the falling edge.
  task automatic push_tx(input gate_ctrl_pkg::tx_event_t ev);
    logic taken;
    tx_evt_data  = ev;
    tx_evt_valid = 1'b1;
    taken        = 1'b0;
    while (!taken)
    begin
      @(negedge aclk);
      taken = tx_evt_ready;
      idle_cycles(1);
    end
    tx_evt_valid = 1'b0;
  endtask

  task automatic push_rx(input gate_ctrl_pkg::rx_event_t ev);
    logic taken;
    rx_evt_data  = ev;
    rx_evt_valid = 1'b1;
    taken        = 1'b0;
    while (!taken)
    begin
      @(negedge aclk);
      taken = rx_evt_ready;
      idle_cycles(1);
    end
    rx_evt_valid = 1'b0;
  endtask

  // Bursts fill the FIFOs and pauses let both blocks go idle.
  task automatic send_tx_events();
    for (int i = 0; i < num_events; i++)
    begin
      push_tx(rand_tx_event());
      if (i % 20 == 19)
        idle_cycles(48);
    end
  endtask

  task automatic send_rx_events();
    for (int i = 0; i < num_events; i++)
    begin
      push_rx(rand_rx_event());
      if (i % 20 == 19)
        idle_cycles(48);
    end
  endtask

  task automatic report_count(input string what, input int got, input int want);
    if (got != want)
    begin
      errors++;
      $display("ERR %s got %h expected %h", what, got, want);
    end
  endtask

  initial
  begin
    seed         = 47270;
    aresetn      = 1'b0;
    tx_evt_data  = '0;
    tx_evt_valid = 1'b0;
    rx_evt_data  = '0;
    rx_evt_valid = 1'b0;
    s_data       = '0;
    s_valid      = 1'b0;
    repeat (5) @(posedge aclk);
    #1;
    aresetn    = 1'b1;
    samples_on = 1'b1;
    fork
      send_tx_events();
      send_rx_events();
    join
    @(negedge aclk);
    while (tx_q.size() != 0 || t_rem != 0 || rx_q.size() != 0 || r_rem != 0)
      @(negedge aclk);
    repeat (4) @(posedge aclk);
    #1;
    report_count("kept_seen", kept_seen, kept_exp);
    if (tx_full_cycles == 0 || rx_full_cycles == 0)
    begin
      errors++;
      $display("An event FIFO never filled, so back-pressure was not reached.");
    end
    $display("Summary: tx events %0d, rx events %0d, kept samples %0d, errors %0d",
             tx_started, rx_started, kept_seen, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/gate_ctrl_pkg.sv
verilog/event_fifo.sv
verilog/tx_event_timer.sv
verilog/rx_sample_gate.sv
verilog/gate_controller_top.sv
verification/gate_controller_tb.sv

// ==== Bender.yml ====
package:
  name: gate_controller

sources:
  - verilog/gate_ctrl_pkg.sv
  - verilog/event_fifo.sv
  - verilog/tx_event_timer.sv
  - verilog/rx_sample_gate.sv
  - verilog/gate_controller_top.sv
  - target: test
    files:
      - verification/gate_controller_tb.sv
